// File: common/mdc_pkg.sv
// mdc_pkg: widths, mode encoding, matrix types and Laplace pairing tables for the determinant unit
`default_nettype none

package mdc_pkg;

    // ==================================================
    // widths and codes
    // ==================================================
    localparam int ENTRY_W      = 11;
    localparam int DATA_CODE_W  = 15;
    localparam int MODE_W       = 5;
    localparam int MODE_CODE_W  = 9;
    localparam int MINOR_W      = 23;
    localparam int DET4_W       = 48;
    localparam int OUT_W        = 207;
    localparam int N_ENTRIES    = 16;
    localparam int N_MINORS_2X2 = 9;
    localparam int N_MINORS_4X4 = 12;
    localparam int TAG_W        = 4;

    // decoded mode word that selects the full determinant
    localparam logic [MODE_W-1:0] MODE_CODE_4X4 = 5'b10110;

    // ==================================================
    // types
    // ==================================================
    typedef logic signed [ENTRY_W-1:0] entry_t;
    typedef logic signed [MINOR_W-1:0] minor_t;

    // row-major, entry (r, c) at index 4*r + c
    typedef entry_t matrix_t [N_ENTRIES];

    typedef enum logic {
        DET_2X2,
        DET_4X4
    } det_mode_e;

    // ==================================================
    // Laplace expansion over rows 0 and 1
    // ==================================================
    // each pair packed as {j1, j2}; pair 5-p is the complement of pair p
    localparam logic [3:0] LAPLACE_TOP_COLS [6] = '{
        4'b0001, 4'b0010, 4'b0011, 4'b0110, 4'b0111, 4'b1011
    };

    // bit p set when pair p is subtracted (j1 + j2 even)
    localparam logic [5:0] LAPLACE_NEG = 6'b010010;

endpackage

`default_nettype wire

// File: common/minor_req_if.sv
// minor_req_if: one 2x2 minor request, four entries and a tag, from scheduler to minor unit
`timescale 1ns/1ps
`default_nettype none

interface minor_req_if import mdc_pkg::*; ();

    // single-cycle strobe, one request per cycle, no back-pressure
    logic             valid;
    logic [TAG_W-1:0] tag;

    // a b on the upper row, c d on the lower row
    entry_t           a;
    entry_t           b;
    entry_t           c;
    entry_t           d;

    modport src (output valid, tag, a, b, c, d);
    modport dst (input valid, tag, a, b, c, d);

endinterface

`default_nettype wire

// File: files.f
common/mdc_pkg.sv
common/minor_req_if.sv
verilog/hamming_decoder.sv
mdc/mdc_matrix_buffer.sv
mdc/mdc_minor_scheduler.sv
mdc/mdc_minor_unit.sv
mdc/mdc_result_combiner.sv
mdc/mdc_top.sv
sim/tb_mdc.sv

// File: mdc/mdc_matrix_buffer.sv
// mdc_matrix_buffer: collects the 16 decoded entries, latches the mode and flags a full matrix
`timescale 1ns/1ps
`default_nettype none

module mdc_matrix_buffer import mdc_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid,
    input  wire entry_t            entry_in,
    input  wire logic [MODE_W-1:0] mode_in,
    output matrix_t                matrix,
    output det_mode_e              mode,
    output logic                   full
);

    localparam int BEAT_W = $clog2(N_ENTRIES);

    logic [BEAT_W-1:0] beat_cnt;

    // beat counter wraps to zero after the last entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            full     <= 1'b0;
            mode     <= DET_2X2;
        end else begin
            full <= in_valid && (beat_cnt == BEAT_W'(N_ENTRIES - 1));
            if (in_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                // mode word rides on the first beat only
                if (beat_cnt == '0) begin
                    mode <= (mode_in == MODE_CODE_4X4) ? DET_4X4 : DET_2X2;
                end
            end
        end
    end

    // entry storage, row-major
    always_ff @(posedge clk) begin
        if (in_valid) begin
            matrix[beat_cnt] <= entry_in;
        end
    end

    // ==================================================
    // checks
    // ==================================================
    // the next matrix must not begin while this one is handed off
    a_no_wrap_on_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        full |-> (beat_cnt == '0) && !in_valid
    );

endmodule

`default_nettype wire

// File: mdc/mdc_minor_scheduler.sv
// mdc_minor_scheduler: steps through the 2x2 minors of the current mode, one request per cycle
`timescale 1ns/1ps
`default_nettype none

module mdc_minor_scheduler import mdc_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire matrix_t   matrix,
    input  wire det_mode_e mode,
    input  wire logic      full,
    minor_req_if.src       req
);

    logic             busy;
    logic [TAG_W-1:0] cnt;
    logic [TAG_W-1:0] last_tag;
    logic [2:0]       pair;
    logic [3:0]       cols;
    logic [1:0]       row;
    logic [1:0]       col_l;
    logic [1:0]       col_r;

    assign last_tag = (mode == DET_4X4) ? TAG_W'(N_MINORS_4X4 - 1) : TAG_W'(N_MINORS_2X2 - 1);
    assign pair     = cnt[TAG_W-1:1];

    // request counter, starts the cycle after full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (full) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            if (cnt == last_tag) begin
                busy <= 1'b0;
                cnt  <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // ==================================================
    // minor selection
    // ==================================================
    always_comb begin
        cols = LAPLACE_TOP_COLS[0];
        if (mode == DET_4X4) begin
            if (!cnt[0]) begin
                row  = 2'd0;
                cols = LAPLACE_TOP_COLS[pair];
            end else begin
                // bottom rows take the complementary column pair
                row  = 2'd2;
                cols = LAPLACE_TOP_COLS[3'd5 - pair];
            end
            col_l = cols[3:2];
            col_r = cols[1:0];
        end else begin
            // block with top-left corner at (k/3, k mod 3)
            row   = 2'(cnt / 4'd3);
            col_l = 2'(cnt % 4'd3);
            col_r = col_l + 2'd1;
        end
    end

    always_comb begin
        req.valid = busy;
        req.tag   = cnt;
        req.a     = matrix[{row, col_l}];
        req.b     = matrix[{row, col_r}];
        req.c     = matrix[{row + 2'd1, col_l}];
        req.d     = matrix[{row + 2'd1, col_r}];
    end

endmodule

`default_nettype wire

// File: mdc/mdc_minor_unit.sv
// mdc_minor_unit: registered 2x2 determinant ad - bc, tag carried alongside the result
`timescale 1ns/1ps
`default_nettype none

module mdc_minor_unit import mdc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    minor_req_if.dst         req,
    output logic             minor_valid,
    output logic [TAG_W-1:0] minor_tag,
    output minor_t           minor_value
);

    minor_t prod_ad;
    minor_t prod_bc;

    // operands widened to the minor width before multiplying
    assign prod_ad = minor_t'(req.a) * minor_t'(req.d);
    assign prod_bc = minor_t'(req.b) * minor_t'(req.c);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minor_valid <= 1'b0;
        end else begin
            minor_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        minor_tag   <= req.tag;
        minor_value <= prod_ad - prod_bc;
    end

    // scheduler never issues beyond the 4x4 request list
    a_tag_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> (req.tag < TAG_W'(N_MINORS_4X4))
    );

endmodule

`default_nettype wire

// File: mdc/mdc_result_combiner.sv
// mdc_result_combiner: gathers minors into the output word or the Laplace sum of the full determinant
`timescale 1ns/1ps
`default_nettype none

module mdc_result_combiner import mdc_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire det_mode_e        mode,
    input  wire logic             minor_valid,
    input  wire logic [TAG_W-1:0] minor_tag,
    input  wire minor_t           minor_value,
    output logic                  out_valid,
    output logic      [OUT_W-1:0] out_data
);

    minor_t                     slots [N_MINORS_2X2];
    minor_t                     top_minor;
    logic signed [DET4_W-1:0]   acc;
    logic signed [2*MINOR_W-1:0] prod;
    logic signed [DET4_W-1:0]   term;
    logic signed [DET4_W-1:0]   acc_base;
    logic [TAG_W-1:0]           last_tag;
    logic [2:0]                 pair;

    assign last_tag = (mode == DET_4X4) ? TAG_W'(N_MINORS_4X4 - 1) : TAG_W'(N_MINORS_2X2 - 1);
    assign pair     = minor_tag[TAG_W-1:1];

    // ==================================================
    // Laplace term
    // ==================================================
    always_comb begin
        prod = top_minor * minor_value;
        term = prod;
        // first bottom minor starts a fresh sum
        acc_base = (minor_tag == TAG_W'(1)) ? '0 : acc;
    end

    always_ff @(posedge clk) begin
        if (minor_valid) begin
            if (mode == DET_4X4) begin
                if (!minor_tag[0]) begin
                    top_minor <= minor_value;
                end else if (LAPLACE_NEG[pair]) begin
                    acc <= acc_base - term;
                end else begin
                    acc <= acc_base + term;
                end
            end else begin
                slots[minor_tag] <= minor_value;
            end
        end
    end

    // result one cycle after the last minor of the mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= minor_valid && (minor_tag == last_tag);
        end
    end

    // ==================================================
    // output packing
    // ==================================================
    always_comb begin
        out_data = '0;
        if (out_valid) begin
            if (mode == DET_4X4) begin
                out_data = {{(OUT_W - DET4_W){acc[DET4_W-1]}}, acc};
            end else begin
                // slot 0 in the top 23 bits
                for (int i = 0; i < N_MINORS_2X2; i++) begin
                    out_data[OUT_W-1-i*MINOR_W -: MINOR_W] = slots[i];
                end
            end
        end
    end

    // one result per matrix, so never two in a row
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid
    );

endmodule

`default_nettype wire

// File: mdc/mdc_top.sv
// mdc_top: matrix determinant calculator, Hamming-coded 4x4 input, 2x2 minors or full determinant
`timescale 1ns/1ps
`default_nettype none

module mdc_top import mdc_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  wire logic [DATA_CODE_W-1:0] in_data,
    input  wire logic [MODE_CODE_W-1:0] in_mode,
    output logic                        out_valid,
    output logic      [OUT_W-1:0]       out_data
);

    entry_t            entry_dec;
    logic [MODE_W-1:0] mode_dec;
    matrix_t           matrix;
    det_mode_e         mode;
    logic              full;
    logic              minor_valid;
    logic [TAG_W-1:0]  minor_tag;
    minor_t            minor_value;

    minor_req_if req_if ();

    // ==================================================
    // input decode
    // ==================================================
    hamming_decoder #(.DATA_W(ENTRY_W)) u_data_dec (
        .code (in_data),
        .data (entry_dec)
    );

    hamming_decoder #(.DATA_W(MODE_W)) u_mode_dec (
        .code (in_mode),
        .data (mode_dec)
    );

    // ==================================================
    // buffer, minor pipeline, output
    // ==================================================
    mdc_matrix_buffer u_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .entry_in (entry_dec),
        .mode_in  (mode_dec),
        .matrix   (matrix),
        .mode     (mode),
        .full     (full)
    );

    mdc_minor_scheduler u_scheduler (
        .clk    (clk),
        .rst_n  (rst_n),
        .matrix (matrix),
        .mode   (mode),
        .full   (full),
        .req    (req_if.src)
    );

    mdc_minor_unit u_minor_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req_if.dst),
        .minor_valid (minor_valid),
        .minor_tag   (minor_tag),
        .minor_value (minor_value)
    );

    mdc_result_combiner u_combiner (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .minor_valid (minor_valid),
        .minor_tag   (minor_tag),
        .minor_value (minor_value),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the determinant calculator testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_mdc -Mdir "$BUILD_DIR" -o tb_mdc
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_mdc" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "run.sh: simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulation exited with status $sim_status"
    exit 1
fi
echo "run.sh: simulation completed"
exit 0

// File: sim/tb_mdc.sv
// tb_mdc: testbench for the determinant calculator, LFSR stimulus with Hamming coding and bit errors
`timescale 1ns/1ps
`default_nettype none

module tb_mdc import mdc_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int LAT_2X2      = 12;
    localparam int LAT_4X4      = 15;
    // upper bound of 40 matrices of 40 cycles each
    localparam int TIMEOUT_NS   = (40 * 40 + RESET_CYCLES) * CLK_PERIOD;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [DATA_CODE_W-1:0] in_data;
    logic [MODE_CODE_W-1:0] in_mode;
    logic                   out_valid;
    logic [OUT_W-1:0]       out_data;

    logic [31:0]      lfsr_state;
    int               mat [N_ENTRIES];
    logic [OUT_W-1:0] expected_q [$];
    int               n_sent;
    int               n_checked;

    mdc_top u_mdc_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_mode   (in_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // MSB is position 1, parity at powers of two, data MSB at position 3
    function automatic logic [14:0] hamming_encode(input logic [10:0] data, input int data_w);
        logic [14:0] code;
        int code_w;
        int k;
        int syn;
        code = '0;
        code_w = data_w + 4;
        k = data_w;
        syn = 0;
        for (int pos = 1; pos <= code_w; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                k = k - 1;
                code[code_w-pos] = data[k];
                if (data[k]) begin
                    syn = syn ^ pos;
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            code[code_w-(1 << i)] = syn[i];
        end
        return code;
    endfunction

    // ==================================================
    // reference model
    // ==================================================
    function automatic longint det3(input longint e [9]);
        return e[0] * (e[4] * e[8] - e[5] * e[7])
             - e[1] * (e[3] * e[8] - e[5] * e[6])
             + e[2] * (e[3] * e[7] - e[4] * e[6]);
    endfunction

    // cofactor expansion along row 0
    function automatic longint det4(input int m [16]);
        longint sum;
        longint sub [9];
        int k;
        sum = 0;
        for (int j = 0; j < 4; j++) begin
            k = 0;
            for (int r = 1; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    if (c != j) begin
                        sub[k] = m[4*r+c];
                        k = k + 1;
                    end
                end
            end
            if (j % 2 == 0) begin
                sum = sum + longint'(m[j]) * det3(sub);
            end else begin
                sum = sum - longint'(m[j]) * det3(sub);
            end
        end
        return sum;
    endfunction

    function automatic logic [OUT_W-1:0] expected_output(input int m [16], input bit use_4x4);
        logic [OUT_W-1:0] res;
        longint v;
        int r0;
        int c0;
        res = '0;
        if (use_4x4) begin
            v = det4(m);
            res = {{(OUT_W - 64){v[63]}}, v};
        end else begin
            // block k has its top-left corner at (k/3, k mod 3), block 0 on top
            for (int k = 0; k < 9; k++) begin
                r0 = k / 3;
                c0 = k % 3;
                v = longint'(m[4*r0+c0]) * m[4*r0+c0+5] - longint'(m[4*r0+c0+1]) * m[4*r0+c0+4];
                res[OUT_W-1-k*MINOR_W -: MINOR_W] = v[MINOR_W-1:0];
            end
        end
        return res;
    endfunction

    // ==================================================
    // checking
    // ==================================================
    task automatic stop_with_failure();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [OUT_W-1:0] got,
                               input logic [OUT_W-1:0] expected);
        if (got !== expected) begin
            $display("Error (%0d ns): %s mismatch, expected %h, got %h",
                     $time, what, expected, got);
            stop_with_failure();
        end
    endtask

    initial begin : compare_proc
        logic [OUT_W-1:0] expected;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid rose at %0d ns with no matrix pending", $time);
                    stop_with_failure();
                end
                expected = expected_q.pop_front();
                check_value("out_data", out_data, expected);
                n_checked = n_checked + 1;
            end else begin
                check_value("idle out_data", out_data, '0);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        stop_with_failure();
    end

    // ==================================================
    // matrix sequences
    // ==================================================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_data  <= '0;
            in_mode  <= '0;
        end
    endtask

    task automatic fill_random();
        logic [31:0] rnd;
        for (int i = 0; i < N_ENTRIES; i++) begin
            rnd = take_bits(ENTRY_W);
            mat[i] = $signed(rnd[ENTRY_W-1:0]);
        end
    endtask

    // 0 all -1024, 1 all 1023, 2 checkerboard of both
    task automatic fill_extreme(input int kind);
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (kind == 0) begin
                mat[i] = -1024;
            end else if (kind == 1) begin
                mat[i] = 1023;
            end else begin
                mat[i] = ((i / 4 + i % 4) % 2 == 0) ? 1023 : -1024;
            end
        end
    endtask

    task automatic send_matrix(input bit use_4x4, input bit inject);
        logic [31:0]            rnd;
        logic [14:0]            code;
        logic [MODE_W-1:0]      mode_word;
        logic [MODE_CODE_W-1:0] mode_code;
        int                     pos;
        int                     latency;
        if (use_4x4) begin
            mode_word = MODE_CODE_4X4;
        end else begin
            rnd = take_bits(MODE_W);
            mode_word = rnd[MODE_W-1:0];
            if (mode_word == MODE_CODE_4X4) begin
                mode_word[0] = ~mode_word[0];
            end
        end
        code = hamming_encode({6'b0, mode_word}, MODE_W);
        mode_code = code[MODE_CODE_W-1:0];
        if (inject) begin
            rnd = take_bits(4);
            pos = int'(rnd % 32'd9);
            mode_code[pos] = ~mode_code[pos];
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            code = hamming_encode(ENTRY_W'(mat[i]), ENTRY_W);
            if (inject) begin
                rnd = take_bits(4);
                pos = int'(rnd % 32'd15);
                code[pos] = ~code[pos];
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data  <= code;
            in_mode  <= (i == 0) ? mode_code : '0;
        end
        expected_q.push_back(expected_output(mat, use_4x4));
        n_sent = n_sent + 1;
        latency = use_4x4 ? LAT_4X4 : LAT_2X2;
        // cycle 0 holds the last beat
        @(negedge clk);
        for (int c = 1; c <= latency; c++) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_data  <= '0;
            in_mode  <= '0;
            @(negedge clk);
            if (c < latency && out_valid) begin
                $display("out_valid came early, %0d cycles after the last beat of matrix %0d",
                         c, n_sent);
                stop_with_failure();
            end else if (c == latency && !out_valid) begin
                $display("out_valid missing %0d cycles after the last beat of matrix %0d",
                         latency, n_sent);
                stop_with_failure();
            end
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_mode    = '0;
        lfsr_state = 32'hae15;
        n_sent     = 0;
        n_checked  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        // quiet outputs before any matrix
        idle(8);

        repeat (6) begin
            fill_random();
            send_matrix(1'b0, 1'b0);
            idle(3);
        end
        repeat (6) begin
            fill_random();
            send_matrix(1'b1, 1'b0);
            idle(3);
        end

        // one flipped bit in every code word
        repeat (4) begin
            fill_random();
            send_matrix(1'b0, 1'b1);
            fill_random();
            send_matrix(1'b1, 1'b1);
            idle(2);
        end

        // back to back from here on, modes alternating
        for (int kind = 0; kind < 3; kind++) begin
            fill_extreme(kind);
            send_matrix(1'b0, 1'b0);
            send_matrix(1'b1, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            fill_random();
            send_matrix(i[0], i[1]);
        end
        idle(4);

        if (expected_q.size() != 0 || n_checked != n_sent) begin
            $display("only %0d of %0d results were checked", n_checked, n_sent);
            stop_with_failure();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hamming_decoder.sv
// hamming_decoder: single-error-correcting Hamming decoder, code word MSB is position 1
`timescale 1ns/1ps
`default_nettype none

module hamming_decoder #(
    parameter int DATA_W = 11
) (
    input  wire logic [DATA_W+$clog2(DATA_W+$clog2(DATA_W)+1)-1:0] code,
    output logic      [DATA_W-1:0]                                  data
);

    // parity bits at positions 1, 2, 4, 8
    localparam int PAR_W  = $clog2(DATA_W + $clog2(DATA_W) + 1);
    localparam int CODE_W = DATA_W + PAR_W;

    logic [PAR_W-1:0]  syndrome;
    logic [CODE_W-1:0] fixed;

    // xor of the positions of all set bits
    always_comb begin
        syndrome = '0;
        for (int pos = 1; pos <= CODE_W; pos++) begin
            if (code[CODE_W-pos]) begin
                syndrome = syndrome ^ PAR_W'(pos);
            end
        end
    end

    // flip the bit the syndrome points at
    always_comb begin
        fixed = code;
        if (syndrome != '0 && int'(syndrome) <= CODE_W) begin
            fixed[CODE_W-int'(syndrome)] = ~code[CODE_W-int'(syndrome)];
        end
    end

    // data bits in ascending position order, first one is the data MSB
    always_comb begin
        int k;
        data = '0;
        k = DATA_W;
        for (int pos = 3; pos <= CODE_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                k = k - 1;
                data[k] = fixed[CODE_W-pos];
            end
        end
    end

endmodule

`default_nettype wire
